// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    // exception code carried with every fetch slot
    typedef logic [4:0] excode_t;

    // slot without exception
    localparam excode_t NO_EX        = 5'd0;

    // both are TLBL in a real cp0
    // split here so decode sees refill and invalid apart
    localparam excode_t TLBL_REFILL  = 5'd2;
    localparam excode_t TLBL_INVALID = 5'd3;

    // misaligned fetch address
    localparam excode_t ADEL         = 5'd4;

    // boot entry in kseg1
    localparam logic [31:0] RESET_VECTOR   = 32'hbfc0_0000;

    // exception entries with BEV set
    // refill has its own entry point
    localparam logic [31:0] REFILL_VECTOR  = 32'hbfc0_0200;
    localparam logic [31:0] GENERAL_VECTOR = 32'hbfc0_0380;

    // kseg0 and kseg1 bypass the tlb
    localparam logic [31:0] UNMAPPED_LO = 32'h8000_0000;
    localparam logic [31:0] UNMAPPED_HI = 32'hbfff_ffff;

    // unmapped translation drops the top three bits
    localparam logic [31:0] PA_MASK     = 32'h1fff_ffff;

    // default instruction memory depth in words
    // kept a power of two so the index is a plain bit slice
    localparam int MEM_DEPTH = 1024;

endpackage

// ==== common/mips_isa_pkg.sv ====
package mips_isa_pkg;

    // primary opcodes the front end cares about
    // J keeps no link, JAL writes ra later in the pipe
    localparam logic [5:0] OP_J   = 6'h02;
    localparam logic [5:0] OP_JAL = 6'h03;

    // one instruction word, two field layouts
    // opcode sits in the same six bits in both views
    typedef union packed {
        // immediate format
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } itype;
        // jump format
        // index is a word offset inside the current 256 MB region
        struct packed {
            logic [5:0]  op;
            logic [25:0] index;
        } jtype;
    } inst_word_u;

endpackage

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter int TLB_ENTRIES = 8,
    parameter int MEM_WORDS   = MEM_DEPTH
)(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           ds_allowin,
    input  logic                           br_taken,
    input  logic [31:0]                    br_target,
    input  logic                           flush,
    input  logic                           flush_refill,
    input  logic                           eret,
    input  logic [31:0]                    epc,
    input  logic                           tlb_we,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_index,
    input  logic [19:0]                    tlb_vpn,
    input  logic [19:0]                    tlb_pfn,
    input  logic                           tlb_v,
    input  logic                           load_we,
    input  logic [31:0]                    load_addr,
    input  logic [31:0]                    load_data,
    output logic                           out_valid,
    output logic [31:0]                    out_pc,
    output logic [31:0]                    out_inst,
    output logic                           out_ex,
    output excode_t                        out_excode
);

    logic        inst_req, addr_ok, data_ok, req_accepted;
    logic [31:0] nextpc, paddr, rdata, fs_pc, jmp_target;
    logic        ps_ex, fs_allowin, jmp_taken;
    logic        itlb_refill, itlb_invalid;
    excode_t     ps_excode;

    // memory takes every request in this design
    assign req_accepted = inst_req & addr_ok;

    pre_if_stage u_pre_if (
        .clk(clk), .reset(reset), .fs_allowin(fs_allowin), .fs_pc(fs_pc),
        .br_taken(br_taken), .br_target(br_target),
        .jmp_taken(jmp_taken), .jmp_target(jmp_target),
        .flush(flush), .flush_refill(flush_refill), .eret(eret), .epc(epc),
        .tlb_ex(itlb_refill | itlb_invalid), .tlb_refill(itlb_refill),
        .inst_req(inst_req), .nextpc(nextpc), .ps_ex(ps_ex),
        .ps_excode(ps_excode), .halted()
    );

    itlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_itlb (
        .clk(clk), .reset(reset), .vaddr(nextpc), .paddr(paddr),
        .ex_refill(itlb_refill), .ex_invalid(itlb_invalid),
        .tlb_we(tlb_we), .tlb_index(tlb_index), .tlb_vpn(tlb_vpn),
        .tlb_pfn(tlb_pfn), .tlb_v(tlb_v)
    );

    inst_mem #(.MEM_WORDS(MEM_WORDS)) u_inst_mem (
        .clk(clk), .req(inst_req), .addr(paddr), .addr_ok(addr_ok),
        .data_ok(data_ok), .rdata(rdata),
        .load_we(load_we), .load_addr(load_addr), .load_data(load_data)
    );

    if_stage u_if (
        .clk(clk), .reset(reset), .nextpc(nextpc), .req_accepted(req_accepted),
        .ps_ex(ps_ex), .ps_excode(ps_excode), .data_ok(data_ok), .rdata(rdata),
        .flush(flush), .eret(eret), .ds_allowin(ds_allowin),
        .fs_allowin(fs_allowin), .fs_pc(fs_pc), .out_valid(out_valid),
        .out_pc(out_pc), .out_inst(out_inst), .out_ex(out_ex), .out_excode(out_excode)
    );

    // jump seen in the output slot
    jump_predecode u_jpd (
        .clk(clk), .reset(reset), .out_valid(out_valid), .out_inst(out_inst),
        .out_pc(out_pc), .ds_allowin(ds_allowin), .flush(flush), .eret(eret),
        .jmp_taken(jmp_taken), .jmp_target(jmp_target)
    );

endmodule

// ==== hw/if_stage.sv ====
`timescale 1ns/1ps

module if_stage
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] nextpc,
    input  logic        req_accepted,
    input  logic        ps_ex,
    input  excode_t     ps_excode,
    input  logic        data_ok,
    input  logic [31:0] rdata,
    input  logic        flush,
    input  logic        eret,
    input  logic        ds_allowin,
    output logic        fs_allowin,
    output logic [31:0] fs_pc,
    output logic        out_valid,
    output logic [31:0] out_pc,
    output logic [31:0] out_inst,
    output logic        out_ex,
    output excode_t     out_excode
);

    logic        kill;
    logic        epoch;
    logic        epoch_now;
    // in-flight entry
    // one deep since memory answers in exactly one cycle
    logic        fl_valid;
    logic        fl_epoch;
    logic [31:0] fl_pc;
    logic        fl_ex;
    excode_t     fl_excode;
    logic        resp_valid;
    logic [31:0] resp_inst;
    logic        slot_free;
    // catches the one response that lands on a held slot
    logic        skid_valid;
    logic [31:0] skid_pc;
    logic [31:0] skid_inst;
    logic        skid_ex;
    excode_t     skid_excode;

    assign kill = flush | eret;
    // requests issued with a redirect already belong to the new epoch
    assign epoch_now = epoch ^ kill;

    // last issued pc feeds the sequential adder
    assign fs_pc = fl_pc;

    // exception slot completes without memory
    assign resp_valid = fl_valid & (fl_ex | data_ok) & (fl_epoch == epoch_now);
    assign resp_inst  = fl_ex ? 32'd0 : rdata;

    assign slot_free  = ~out_valid | ds_allowin;
    // a redirect empties the slot so its request may go out
    assign fs_allowin = slot_free | kill;

    always_ff @(posedge clk) begin
        if (reset) begin
            epoch    <= 1'b0;
            fl_valid <= 1'b0;
        end else begin
            epoch    <= epoch_now;
            fl_valid <= req_accepted | ps_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (req_accepted || ps_ex) begin
            fl_pc     <= nextpc;
            fl_epoch  <= epoch_now;
            fl_ex     <= ps_ex;
            fl_excode <= ps_excode;
        end
    end

    // skid is empty whenever a response can arrive on a free slot
    always_ff @(posedge clk) begin
        if (reset || kill) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (slot_free) begin
            out_valid  <= skid_valid | resp_valid;
            skid_valid <= 1'b0;
        end else if (resp_valid) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (slot_free) begin
            out_pc     <= skid_valid ? skid_pc : fl_pc;
            out_inst   <= skid_valid ? skid_inst : resp_inst;
            out_ex     <= skid_valid ? skid_ex : fl_ex;
            out_excode <= skid_valid ? skid_excode : fl_excode;
        end else if (resp_valid) begin
            skid_pc     <= fl_pc;
            skid_inst   <= resp_inst;
            skid_ex     <= fl_ex;
            skid_excode <= fl_excode;
        end
    end

endmodule

// ==== hw/inst_mem.sv ====
`timescale 1ns/1ps

module inst_mem #(
    parameter int MEM_WORDS = 1024
)(
    input  logic        clk,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata,
    input  logic        load_we,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [31:0]   mem [MEM_WORDS];
    logic [AW-1:0] rd_idx;
    logic [AW-1:0] ld_idx;

    // byte addresses in, word index out
    // upper bits wrap modulo the depth
    assign rd_idx = addr[AW+1:2];
    assign ld_idx = load_addr[AW+1:2];

    // never busy
    assign addr_ok = req;

    // one read per accepted request
    // answer comes back one cycle later
    always_ff @(posedge clk) begin
        data_ok <= req;
        if (req) begin
            rdata <= mem[rd_idx];
        end
    end

    // program loader
    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[ld_idx] <= load_data;
        end
    end

endmodule

// ==== hw/itlb/itlb.sv ====
`timescale 1ns/1ps

module itlb
    import fetch_pkg::*;
#(
    parameter int TLB_ENTRIES = 8
)(
    input  logic                           clk,
    input  logic                           reset,
    input  logic [31:0]                    vaddr,
    output logic [31:0]                    paddr,
    output logic                           ex_refill,
    output logic                           ex_invalid,
    input  logic                           tlb_we,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_index,
    input  logic [19:0]                    tlb_vpn,
    input  logic [19:0]                    tlb_pfn,
    input  logic                           tlb_v
);

    // entry written at least once since reset
    logic [TLB_ENTRIES-1:0] present;
    // entry payload
    logic [19:0]            vpn_q [TLB_ENTRIES];
    logic [19:0]            pfn_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] v_q;

    logic        unmapped;
    logic        hit;
    logic        hit_v;
    logic [19:0] hit_pfn;

    // kseg0 and kseg1 never look at the tlb
    assign unmapped = (vaddr >= UNMAPPED_LO) && (vaddr <= UNMAPPED_HI);

    // parallel compare on the 4 KB page number
    // software keeps entries unique so at most one hits
    always_comb begin
        hit     = 1'b0;
        hit_v   = 1'b0;
        hit_pfn = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (present[i] && (vpn_q[i] == vaddr[31:12])) begin
                hit     = 1'b1;
                hit_v   = v_q[i];
                hit_pfn = pfn_q[i];
            end
        end
    end

    // page offset passes straight through
    assign paddr = unmapped ? (vaddr & PA_MASK) : {hit_pfn, vaddr[11:0]};

    // no entry at all
    assign ex_refill  = ~unmapped & ~hit;
    // entry found with V clear
    assign ex_invalid = ~unmapped & hit & ~hit_v;

    always_ff @(posedge clk) begin
        if (reset) begin
            present <= '0;
        end else if (tlb_we) begin
            present[tlb_index] <= 1'b1;
        end
    end

    // write port
    // a rewrite of a slot simply replaces it
    always_ff @(posedge clk) begin
        if (tlb_we) begin
            vpn_q[tlb_index] <= tlb_vpn;
            pfn_q[tlb_index] <= tlb_pfn;
            v_q[tlb_index]   <= tlb_v;
        end
    end

endmodule

// ==== hw/jump_predecode.sv ====
`timescale 1ns/1ps

module jump_predecode
    import mips_isa_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        out_valid,
    input  logic [31:0] out_inst,
    input  logic [31:0] out_pc,
    input  logic        ds_allowin,
    input  logic        flush,
    input  logic        eret,
    output logic        jmp_taken,
    output logic [31:0] jmp_target
);

    inst_word_u  iw;
    logic        is_jump;
    // redirect already given for the jump in the slot
    logic        fired;
    logic [31:0] ds_pc;

    assign iw      = out_inst;
    assign is_jump = out_valid && ((iw.jtype.op == OP_J) || (iw.jtype.op == OP_JAL));

    // region comes from the delay slot pc
    assign ds_pc      = out_pc + 32'd4;
    assign jmp_target = {ds_pc[31:28], iw.jtype.index, 2'b00};

    // first cycle the jump sits in the slot
    // its delay slot was requested the cycle before
    assign jmp_taken = is_jump & ~fired & ~flush & ~eret;

    always_ff @(posedge clk) begin
        if (reset || flush || eret) begin
            fired <= 1'b0;
        end else if (out_valid && ds_allowin) begin
            fired <= 1'b0;
        end else if (jmp_taken) begin
            fired <= 1'b1;
        end
    end

endmodule

// ==== hw/pre_if_stage.sv ====
`timescale 1ns/1ps

module pre_if_stage
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        fs_allowin,
    input  logic [31:0] fs_pc,
    input  logic        br_taken,
    input  logic [31:0] br_target,
    input  logic        jmp_taken,
    input  logic [31:0] jmp_target,
    input  logic        flush,
    input  logic        flush_refill,
    input  logic        eret,
    input  logic [31:0] epc,
    input  logic        tlb_ex,
    input  logic        tlb_refill,
    output logic        inst_req,
    output logic [31:0] nextpc,
    output logic        ps_ex,
    output excode_t     ps_excode,
    output logic        halted
);

    // a memory request went out last cycle
    logic        issued_r;
    // pc to retry after a stalled cycle
    logic [31:0] pc_buf;
    logic [31:0] seq_pc;
    logic [31:0] flush_vec;
    logic        adel;
    logic        any_ex;
    logic        issue_en;

    assign seq_pc = fs_pc + 32'd4;

    // refill misses have their own entry point
    assign flush_vec = flush_refill ? REFILL_VECTOR : GENERAL_VECTOR;

    // timely path
    // the redirect lands on the request of this very cycle
    // a flush always opens the slot, so its vector goes out at once
    always_comb begin
        if (flush) begin
            nextpc = flush_vec;
        end else if (eret) begin
            nextpc = epc;
        end else if (jmp_taken) begin
            nextpc = jmp_target;
        end else if (issued_r) begin
            // outside branch only matters on a sequential step
            nextpc = br_taken ? br_target : seq_pc;
        end else begin
            nextpc = pc_buf;
        end
    end

    // halted until the later stages redirect
    // nothing goes out while in reset
    assign issue_en = ~reset & fs_allowin & (~halted | flush | eret);

    assign adel   = nextpc[1:0] != 2'b00;
    assign any_ex = adel | tlb_ex;

    // faulting address never reaches memory
    assign inst_req = issue_en & ~any_ex;
    assign ps_ex    = issue_en & any_ex;

    // address error wins over tlb
    always_comb begin
        if (adel) begin
            ps_excode = ADEL;
        end else if (tlb_ex) begin
            ps_excode = tlb_refill ? TLBL_REFILL : TLBL_INVALID;
        end else begin
            ps_excode = NO_EX;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issued_r <= 1'b0;
            pc_buf   <= RESET_VECTOR;
        end else begin
            issued_r <= inst_req;
            // whatever was chosen and not taken is retried
            pc_buf   <= nextpc;
        end
    end

    // stop after an exception slot
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (ps_ex) begin
            halted <= 1'b1;
        end else if (flush || eret) begin
            halted <= 1'b0;
        end
    end

endmodule

// ==== sim/fetch_sva.sv ====
`timescale 1ns/1ps

module fetch_sva
    import fetch_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        ds_allowin,
    input logic        flush,
    input logic        eret,
    input logic        inst_req,
    input logic        addr_ok,
    input logic        data_ok,
    input logic        out_valid,
    input logic [31:0] out_pc,
    input logic [31:0] out_inst,
    input logic        out_ex,
    input excode_t     out_excode
);

    // nothing is checked before the first reset
    logic armed;

    initial armed = 1'b0;

    always @(posedge clk) begin
        if (reset) begin
            armed <= 1'b1;
        end
    end

    // slot empty right after reset
    a_reset_empty: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // a slot only appears from a response or an exception
    a_rise_has_source: assert property (@(posedge clk) disable iff (reset || !armed)
        $rose(out_valid) |-> $past(data_ok) || out_ex)
        else $error("out_valid rose with no memory response and no exception");

    // held slot frozen unless killed
    a_hold_stable: assert property (@(posedge clk) disable iff (reset || !armed)
        out_valid && !ds_allowin && !flush && !eret |=>
            out_valid && $stable({out_pc, out_inst, out_ex, out_excode}))
        else $error("output slot changed while held");

    // one cycle memory latency
    a_data_after_req: assert property (@(posedge clk) disable iff (reset || !armed)
        inst_req && addr_ok |=> data_ok)
        else $error("data_ok missing one cycle after an accepted request");

    a_data_has_req: assert property (@(posedge clk) disable iff (reset || !armed)
        data_ok |-> $past(inst_req && addr_ok))
        else $error("data_ok without an accepted request");

endmodule

bind fetch_top fetch_sva u_sva (
    .clk(clk),
    .reset(reset),
    .ds_allowin(ds_allowin),
    .flush(flush),
    .eret(eret),
    .inst_req(inst_req),
    .addr_ok(addr_ok),
    .data_ok(data_ok),
    .out_valid(out_valid),
    .out_pc(out_pc),
    .out_inst(out_inst),
    .out_ex(out_ex),
    .out_excode(out_excode)
);

// ==== sim/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb
    import fetch_pkg::*;
    import mips_isa_pkg::*;
();

    // J placed at RV+0x104, lands on RV+0x400
    localparam logic [31:0] JUMP_PC     = RESET_VECTOR + 32'h104;
    localparam logic [31:0] JUMP_TARGET = RESET_VECTOR + 32'h400;

    logic        clk = 1'b0;
    logic        reset = 1'b0;
    logic        ds_allowin = 1'b1;
    logic        br_taken = 1'b0;
    logic [31:0] br_target = '0;
    logic        flush = 1'b0;
    logic        flush_refill = 1'b0;
    logic        eret = 1'b0;
    logic [31:0] epc = '0;
    logic        tlb_we = 1'b0;
    logic [2:0]  tlb_index = '0;
    logic [19:0] tlb_vpn = '0;
    logic [19:0] tlb_pfn = '0;
    logic        tlb_v = 1'b0;
    logic        load_we = 1'b0;
    logic [31:0] load_addr = '0;
    logic [31:0] load_data = '0;
    logic        out_valid;
    logic [31:0] out_pc;
    logic [31:0] out_inst;
    logic        out_ex;
    excode_t     out_excode;
    logic [69:0] out_slot;

    // reference copies of memory and tlb
    logic [31:0] mem_model [MEM_DEPTH];
    logic [19:0] m_vpn [8];
    logic [19:0] m_pfn [8];
    logic [7:0]  m_v = '0;
    logic [7:0]  m_present = '0;

    // slot layout is pc, inst, ex, code
    logic [69:0] obs [$];
    logic [69:0] exp_q [$];
    int          obs_cyc [$];
    logic [69:0] held_val;
    logic        held = 1'b0;
    logic        rand_on = 1'b0;
    int          cyc = 0;
    integer      seed = 32'h5a44;
    string       cur_test = "init";
    int          test_errors = 0;
    int          total_errors = 0;
    int          failed_tests = 0;

    always #4 clk = ~clk;

    fetch_top u_dut (.*);

    assign out_slot = {out_pc, out_inst, out_ex, out_excode};

    // decode side model
    // new allowin applies to the coming rising edge
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (held && out_valid && out_slot !== held_val) begin
            $display("** Error %s: held slot changed, expected %h actual %h",
                     cur_test, held_val, out_slot);
            test_errors++;
        end
        ds_allowin = rand_on ? (($random(seed) & 1) != 0) : 1'b1;
        if (out_valid && ds_allowin) begin
            obs.push_back(out_slot);
            obs_cyc.push_back(cyc);
        end
        held = out_valid && !ds_allowin;
        held_val = out_slot;
    end

    // what decode should see for a fetch at va
    function automatic logic [69:0] ref_slot(input logic [31:0] va);
        logic [31:0] pa;
        logic        hit;
        logic        valid;
        int          i;
        pa = va & PA_MASK;
        hit = 1'b0;
        valid = 1'b0;
        if (va[1:0] != 2'b00)
            return {va, 32'd0, 1'b1, ADEL};
        if (va < UNMAPPED_LO || va > UNMAPPED_HI) begin
            for (i = 0; i < 8; i++) begin
                if (m_present[i] && m_vpn[i] == va[31:12]) begin
                    hit = 1'b1;
                    valid = m_v[i];
                    pa = {m_pfn[i], va[11:0]};
                end
            end
            if (!hit)
                return {va, 32'd0, 1'b1, TLBL_REFILL};
            if (!valid)
                return {va, 32'd0, 1'b1, TLBL_INVALID};
        end
        return {va, mem_model[(pa >> 2) % MEM_DEPTH], 1'b0, NO_EX};
    endfunction

    task automatic expect_run(input logic [31:0] start, input int n);
        int k;
        for (k = 0; k < n; k++)
            exp_q.push_back(ref_slot(start + 32'(4 * k)));
    endtask

    // filler never decodes as a jump
    task automatic load_program();
        logic [31:0] a;
        logic [31:0] rnd;
        inst_word_u  jw;
        int          i;
        for (i = 0; i < MEM_DEPTH; i++) begin
            a = (RESET_VECTOR & PA_MASK) + 32'(i * 4);
            rnd = $random(seed);
            mem_model[i] = {6'h09, rnd[25:0] ^ a[27:2] ^ {22'd0, a[31:28]}};
        end
        jw.jtype.op = OP_J;
        jw.jtype.index = JUMP_TARGET[27:2];
        mem_model[JUMP_PC[11:2]] = jw;
        for (i = 0; i < MEM_DEPTH; i++) begin
            @(negedge clk);
            load_we = 1'b1;
            load_addr = (RESET_VECTOR & PA_MASK) + 32'(i * 4);
            load_data = mem_model[i];
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    task automatic write_tlb(input int idx, input logic [19:0] vpn,
                             input logic [19:0] pfn, input logic v);
        @(negedge clk);
        tlb_we = 1'b1;
        tlb_index = 3'(idx);
        tlb_vpn = vpn;
        tlb_pfn = pfn;
        tlb_v = v;
        @(negedge clk);
        tlb_we = 1'b0;
        m_present[idx] = 1'b1;
        m_vpn[idx] = vpn;
        m_pfn[idx] = pfn;
        m_v[idx] = v;
    endtask

    // kind 0 eret, 1 flush, 2 flush to refill vector
    task automatic redirect(input int kind, input logic [31:0] pc);
        @(negedge clk);
        eret = (kind == 0);
        flush = (kind != 0);
        flush_refill = (kind == 2);
        epc = pc;
        @(negedge clk);
        eret = 1'b0;
        flush = 1'b0;
        flush_refill = 1'b0;
        obs.delete();
        obs_cyc.delete();
        exp_q.delete();
    endtask

    task automatic wait_items(input int n);
        int t;
        t = 0;
        while (obs.size() < n && t < 300) begin
            @(posedge clk);
            t++;
        end
        if (obs.size() < n) begin
            $display("%s: timed out waiting for fetch output, got %0d of %0d slots",
                     cur_test, obs.size(), n);
            test_errors++;
        end
    endtask

    task automatic check_stream();
        logic [69:0] e;
        logic [69:0] o;
        int          i;
        for (i = 0; i < exp_q.size() && i < obs.size(); i++) begin
            e = exp_q[i];
            o = obs[i];
            if (o !== e) begin
                $display("** Error %s: slot %0d expected pc %h inst %h ex %b code %0d, %s",
                         cur_test, i, e[69:38], e[37:6], e[5], e[4:0],
                         $sformatf("actual pc %h inst %h ex %b code %0d",
                                   o[69:38], o[37:6], o[5], o[4:0]));
                test_errors++;
            end
        end
    endtask

    // exception slot must be the last thing out
    task automatic expect_quiet();
        int t;
        for (t = 0; t < 16; t++)
            @(posedge clk);
        if (obs.size() != exp_q.size()) begin
            $display("%s: fetch kept delivering after an exception slot", cur_test);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: %0d errors", cur_test, test_errors);
            failed_tests++;
        end
        total_errors += test_errors;
    endtask

    task automatic test_sequential();
        int i;
        start_test("sequential");
        expect_run(RESET_VECTOR, 16);
        wait_items(16);
        check_stream();
        for (i = 1; i < obs_cyc.size(); i++) begin
            if (obs_cyc[i] != obs_cyc[i-1] + 1) begin
                $display("%s: gap in the stream before slot %0d", cur_test, i);
                test_errors++;
            end
        end
        finish_test();
    endtask

    task automatic test_backpressure();
        start_test("backpressure");
        redirect(0, RESET_VECTOR);
        rand_on = 1'b1;
        expect_run(RESET_VECTOR, 16);
        wait_items(16);
        rand_on = 1'b0;
        check_stream();
        finish_test();
    endtask

    task automatic test_jump_branch();
        start_test("jump_branch");
        // J, its delay slot, then the target
        redirect(0, JUMP_PC - 32'd4);
        expect_run(JUMP_PC - 32'd4, 3);
        expect_run(JUMP_TARGET, 3);
        wait_items(6);
        check_stream();
        // branch pulse on the third request
        redirect(0, RESET_VECTOR + 32'h600);
        @(negedge clk);
        br_taken = 1'b1;
        br_target = RESET_VECTOR + 32'h700;
        @(negedge clk);
        br_taken = 1'b0;
        expect_run(RESET_VECTOR + 32'h600, 2);
        expect_run(RESET_VECTOR + 32'h700, 3);
        wait_items(5);
        check_stream();
        finish_test();
    endtask

    task automatic test_flush_eret();
        start_test("flush_eret");
        redirect(1, 32'd0);
        expect_run(GENERAL_VECTOR, 3);
        wait_items(3);
        check_stream();
        redirect(2, 32'd0);
        expect_run(REFILL_VECTOR, 3);
        wait_items(3);
        check_stream();
        redirect(0, RESET_VECTOR + 32'h800);
        expect_run(RESET_VECTOR + 32'h800, 3);
        wait_items(3);
        check_stream();
        finish_test();
    endtask

    task automatic test_translation();
        start_test("translation");
        write_tlb(0, 20'h00400, 20'h1fc00, 1'b1);
        write_tlb(1, 20'h00600, 20'h1fc01, 1'b0);
        redirect(0, 32'h0040_0a00);
        expect_run(32'h0040_0a00, 3);
        wait_items(3);
        check_stream();
        // no entry, V clear, misaligned
        redirect(0, 32'h0050_0000);
        expect_run(32'h0050_0000, 1);
        wait_items(1);
        check_stream();
        expect_quiet();
        redirect(0, 32'h0060_0000);
        expect_run(32'h0060_0000, 1);
        wait_items(1);
        check_stream();
        expect_quiet();
        redirect(0, RESET_VECTOR + 32'd2);
        expect_run(RESET_VECTOR + 32'd2, 1);
        wait_items(1);
        check_stream();
        expect_quiet();
        redirect(1, 32'd0);
        expect_run(GENERAL_VECTOR, 2);
        wait_items(2);
        check_stream();
        finish_test();
    endtask

    initial begin
        load_program();
        reset = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        obs.delete();
        obs_cyc.delete();
        test_sequential();
        test_backpressure();
        test_jump_branch();
        test_flush_eret();
        test_translation();
        $display("tests run 5, failed %0d, errors %0d", failed_tests, total_errors);
        if (failed_tests == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/fetch_pkg.sv
common/mips_isa_pkg.sv
hw/pre_if_stage.sv
hw/itlb/itlb.sv
hw/inst_mem.sv
hw/if_stage.sv
hw/jump_predecode.sv
hw/fetch_top.sv
sim/fetch_sva.sv
sim/fetch_tb.sv
